// ==== Bender.yml ====
package:
  name: bank_htu

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/bank_htu_pkg.sv
      - verilog/bank_htu_req_stage.sv
      - verilog/bank_htu_set_entry.sv
      - verilog/bank_htu_resp_stage.sv
      - verilog/bank_htu.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/bank_htu_clk_gen.sv
      - testbench/bank_htu_properties.sv
      - testbench/tb_bank_htu.sv

// ==== include/bank_htu_params.svh ====
`ifndef BANK_HTU_PARAMS_SVH
`define BANK_HTU_PARAMS_SVH

// tag array geometry
`define BANK_HTU_SETS 8
`define BANK_HTU_WAYS 8
`define BANK_HTU_SET_W 3
`define BANK_HTU_WAY_W 3

// request address holds bits 31:4
`define BANK_HTU_ADDR_W 28
// tag is address bits 31:8
`define BANK_HTU_TAG_W 24

// request side ids
`define BANK_HTU_CH_ID_W 2
`define BANK_HTU_WBUF_ID_W 8

`endif

// ==== tb.f ====
+incdir+include
verilog/bank_htu_pkg.sv
verilog/bank_htu_req_stage.sv
verilog/bank_htu_set_entry.sv
verilog/bank_htu_resp_stage.sv
verilog/bank_htu.sv
testbench/bank_htu_clk_gen.sv
testbench/bank_htu_properties.sv
testbench/tb_bank_htu.sv

// ==== testbench/bank_htu_clk_gen.sv ====
module bank_htu_clk_gen (
  output logic clk_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // 4 ns period
  localparam time half_period = 2ns;

  initial begin
    clk_o = 1'b0;
  end

  always begin
    #(half_period);
    clk_o = ~clk_o;
  end

endmodule

// ==== testbench/bank_htu_properties.sv ====
module bank_htu_properties (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input logic                   req_valid_i,
  input logic                   req_ready_o,
  input bank_htu_pkg::htu_req_t req_i,
  input logic                   rsp_valid_o,
  input logic                   rsp_ready_i,
  input bank_htu_pkg::htu_rsp_t rsp_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // stalled response holds valid and payload
  a_rsp_stable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o)
  ) else $error("rsp_o changed while stalled");

  a_no_rsvd: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i && req_ready_o |-> req_i.opcode != bank_htu_pkg::OP_RSVD
  ) else $error("reserved opcode accepted");

  // evict only comes with an allocating miss
  a_no_evict_on_hit: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_o |-> !(rsp_o.evict && rsp_o.hit)
  ) else $error("evict reported on a hit");

endmodule

// ==== testbench/tb_bank_htu.sv ====
`include "bank_htu_params.svh"

module tb_bank_htu;

  timeunit 1ns;
  timeprecision 1ps;

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   req_valid_i;
  logic                   req_ready_o;
  bank_htu_pkg::htu_req_t req_i;
  logic                   rsp_valid_o;
  logic                   rsp_ready_i;
  bank_htu_pkg::htu_rsp_t rsp_o;

  integer seed = 1;
  int     errors = 0;
  int     acc_cnt = 0;
  int     rsp_cnt = 0;
  int     hit_cnt = 0;
  int     evict_cnt = 0;
  int     fill_cnt = 0;
  int     id_cnt = 0;
  bit     timed_out = 1'b0;

  logic [`BANK_HTU_TAG_W-1:0] tag_pool [12];
  bank_htu_pkg::htu_rsp_t     exp_q [$];
  bank_htu_pkg::htu_rsp_t     exp_rsp;

  // reference tag array
  logic [`BANK_HTU_TAG_W-1:0] m_tag    [`BANK_HTU_SETS][`BANK_HTU_WAYS];
  logic                       m_valid  [`BANK_HTU_SETS][`BANK_HTU_WAYS];
  bank_htu_pkg::line_state_e  m_st0    [`BANK_HTU_SETS][`BANK_HTU_WAYS];
  bank_htu_pkg::line_state_e  m_st1    [`BANK_HTU_SETS][`BANK_HTU_WAYS];
  logic [`BANK_HTU_WAY_W-1:0] m_victim [`BANK_HTU_SETS];

  bank_htu_clk_gen i_clk_gen (
    .clk_o (clk_i)
  );

  bank_htu i_bank_htu (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_o       (rsp_o)
  );

  bind bank_htu bank_htu_properties i_bank_htu_props (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_o       (rsp_o)
  );

  //--------------------------------------------------------------------
  // reference model
  //--------------------------------------------------------------------
  function automatic bank_htu_pkg::htu_rsp_t predict_rsp(input bank_htu_pkg::htu_req_t r);
    bank_htu_pkg::htu_rsp_t     e;
    logic [`BANK_HTU_SET_W-1:0] s;
    logic [`BANK_HTU_TAG_W-1:0] t;
    logic [`BANK_HTU_WAY_W-1:0] w;
    logic                       off;
    logic                       hit;
    logic                       alloc;
    bank_htu_pkg::line_state_e  acc;
    s   = r.addr[3:1];
    t   = r.addr[27:4];
    off = r.addr[0];
    hit = 1'b0;
    w   = m_victim[s];
    for (int i = 0; i < `BANK_HTU_WAYS; i++) begin
      if (m_valid[s][i] && m_tag[s][i] == t) begin
        hit = 1'b1;
        w   = i;
      end
    end
    alloc = (r.opcode == bank_htu_pkg::OP_READ || r.opcode == bank_htu_pkg::OP_WRITE) && !hit;
    acc   = off ? m_st1[s][w] : m_st0[s][w];
    e            = '0;
    e.ch_id      = r.ch_id;
    e.write      = r.opcode == bank_htu_pkg::OP_WRITE;
    e.hit        = hit;
    e.set        = s;
    e.way        = w;
    e.offset     = off;
    e.wbuffer_id = r.wbuffer_id;
    e.state0     = m_st0[s][w];
    e.state1     = m_st1[s][w];
    e.evict      = alloc && m_valid[s][w] &&
                   (m_st0[s][w] == bank_htu_pkg::ST_DIRTY || m_st1[s][w] == bank_htu_pkg::ST_DIRTY);
    e.linefill   = r.opcode == bank_htu_pkg::OP_READ && (!hit || acc == bank_htu_pkg::ST_EMPTY);
    // apply the update for later requests
    if (alloc) begin
      m_tag[s][w]   = t;
      m_valid[s][w] = 1'b1;
      m_st0[s][w]   = bank_htu_pkg::ST_EMPTY;
      m_st1[s][w]   = bank_htu_pkg::ST_EMPTY;
      m_victim[s]   = m_victim[s] + 1'b1;
    end
    if (r.opcode == bank_htu_pkg::OP_READ) begin
      if (off && m_st1[s][w] == bank_htu_pkg::ST_EMPTY) begin
        m_st1[s][w] = bank_htu_pkg::ST_CLEAN;
      end else if (!off && m_st0[s][w] == bank_htu_pkg::ST_EMPTY) begin
        m_st0[s][w] = bank_htu_pkg::ST_CLEAN;
      end
    end else if (r.opcode == bank_htu_pkg::OP_WRITE) begin
      if (off) begin
        m_st1[s][w] = bank_htu_pkg::ST_DIRTY;
      end else begin
        m_st0[s][w] = bank_htu_pkg::ST_DIRTY;
      end
    end else if (r.opcode == bank_htu_pkg::OP_INVAL && hit) begin
      m_valid[s][w] = 1'b0;
      m_st0[s][w]   = bank_htu_pkg::ST_EMPTY;
      m_st1[s][w]   = bank_htu_pkg::ST_EMPTY;
    end
    return e;
  endfunction

  task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp_v);
    if (got !== exp_v) begin
      errors++;
      $display("CHECK FAILED t=%0t %s got=%0h exp=%0h", $time, name, got, exp_v);
    end
  endtask

  task automatic compare_rsp(input bank_htu_pkg::htu_rsp_t got, input bank_htu_pkg::htu_rsp_t e);
    check_field("rsp_o.ch_id", got.ch_id, e.ch_id);
    check_field("rsp_o.write", got.write, e.write);
    check_field("rsp_o.evict", got.evict, e.evict);
    check_field("rsp_o.hit", got.hit, e.hit);
    check_field("rsp_o.linefill", got.linefill, e.linefill);
    check_field("rsp_o.set", got.set, e.set);
    check_field("rsp_o.way", got.way, e.way);
    check_field("rsp_o.offset", got.offset, e.offset);
    check_field("rsp_o.wbuffer_id", got.wbuffer_id, e.wbuffer_id);
    check_field("rsp_o.state0", got.state0, e.state0);
    check_field("rsp_o.state1", got.state1, e.state1);
    hit_cnt   += e.hit;
    evict_cnt += e.evict;
    fill_cnt  += e.linefill;
  endtask

  //--------------------------------------------------------------------
  // stimulus
  //--------------------------------------------------------------------
  task automatic send_req(input bank_htu_pkg::htu_opcode_e op, input int tag_idx,
                          input logic [`BANK_HTU_SET_W-1:0] set, input logic off);
    int waited;
    if (timed_out) begin
      return;
    end
    req_valid_i      <= 1'b1;
    req_i.ch_id      <= id_cnt[1:0];
    req_i.opcode     <= op;
    req_i.addr       <= {tag_pool[tag_idx], set, off};
    req_i.wbuffer_id <= id_cnt[7:0];
    id_cnt++;
    waited = 0;
    do begin
      @(posedge clk_i);
      waited++;
    end while (!req_ready_o && waited < 200);
    if (!req_ready_o) begin
      errors++;
      timed_out = 1'b1;
      $display("timeout: request not accepted within 200 cycles at %0t", $time);
    end
    req_valid_i <= 1'b0;
  endtask

  // random back-pressure
  initial begin
    forever begin
      @(posedge clk_i);
      rsp_ready_i <= ($random(seed) & 3) != 0;
    end
  end

  // predict at acceptance
  initial begin
    forever begin
      @(posedge clk_i);
      if (rst_n_i && req_valid_i && req_ready_o) begin
        exp_q.push_back(predict_rsp(req_i));
        acc_cnt++;
      end
    end
  end

  initial begin
    forever begin
      @(posedge clk_i);
      if (rsp_valid_o && rsp_ready_i) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("response at %0t with no outstanding request", $time);
        end else begin
          exp_rsp = exp_q.pop_front();
          compare_rsp(rsp_o, exp_rsp);
          rsp_cnt++;
        end
      end
    end
  end

  initial begin
    int                         waited;
    int                         sel;
    bank_htu_pkg::htu_opcode_e  op;
    req_valid_i = 1'b0;
    req_i       = '0;
    rsp_ready_i = 1'b0;
    rst_n_i     = 1'b0;
    for (int i = 0; i < 12; i++) begin
      tag_pool[i] = 24'h5a_0000 ^ (i * 24'h01_3a17);
    end
    for (int s = 0; s < `BANK_HTU_SETS; s++) begin
      m_victim[s] = '0;
      for (int w = 0; w < `BANK_HTU_WAYS; w++) begin
        m_valid[s][w] = 1'b0;
        m_st0[s][w]   = bank_htu_pkg::ST_EMPTY;
        m_st1[s][w]   = bank_htu_pkg::ST_EMPTY;
      end
    end
    repeat (16) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    if (rsp_valid_o !== 1'b0) begin
      errors++;
      $display("CHECK FAILED t=%0t rsp_valid_o got=%0b exp=0", $time, rsp_valid_o);
    end
    if (req_ready_o !== 1'b1) begin
      errors++;
      $display("CHECK FAILED t=%0t req_ready_o got=%0b exp=1", $time, req_ready_o);
    end

    // first fill per set, hits on both halves, then a write
    for (int s = 0; s < `BANK_HTU_SETS; s++) begin
      send_req(bank_htu_pkg::OP_READ, 0, s, 1'b0);
      send_req(bank_htu_pkg::OP_READ, 0, s, 1'b0);
      send_req(bank_htu_pkg::OP_READ, 0, s, 1'b1);
      send_req(bank_htu_pkg::OP_WRITE, 0, s, 1'b1);
    end
    // eight more misses in set 0 wrap onto the dirty way
    for (int t = 1; t <= 8; t++) begin
      send_req(bank_htu_pkg::OP_READ, t, 0, 1'b0);
    end
    send_req(bank_htu_pkg::OP_INVAL, 1, 0, 1'b0);
    send_req(bank_htu_pkg::OP_READ, 1, 0, 1'b0);
    send_req(bank_htu_pkg::OP_INVAL, 11, 0, 1'b0);
    send_req(bank_htu_pkg::OP_READ, 2, 0, 1'b1);

    //------------------------------------------------------------------
    // random traffic
    //------------------------------------------------------------------
    for (int n = 0; n < 400; n++) begin
      if (timed_out) begin
        break;
      end
      if (($random(seed) & 3) == 0) begin
        @(posedge clk_i);
      end
      sel = $random(seed) & 7;
      op  = sel < 4 ? bank_htu_pkg::OP_READ :
            sel < 7 ? bank_htu_pkg::OP_WRITE : bank_htu_pkg::OP_INVAL;
      send_req(op, $unsigned($random(seed)) % 12, $random(seed) & 7, $random(seed) & 1);
    end

    // last acceptance is counted on the edge that ended send_req
    waited = 0;
    do begin
      @(posedge clk_i);
      waited++;
    end while (rsp_cnt != acc_cnt && waited < 1000);
    if (rsp_cnt != acc_cnt) begin
      errors++;
      $display("timeout: %0d responses still missing", acc_cnt - rsp_cnt);
    end
    if (evict_cnt == 0 || hit_cnt == 0 || fill_cnt == 0) begin
      errors++;
      $display("traffic never produced a hit, an eviction and a linefill");
    end
    $display("errors=%0d requests=%0d responses=%0d hits=%0d evicts=%0d linefills=%0d",
             errors, acc_cnt, rsp_cnt, hit_cnt, evict_cnt, fill_cnt);
    if (errors == 0 && !timed_out) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== verilog/bank_htu.sv ====
`include "bank_htu_params.svh"

module bank_htu (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // crossbar side
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  bank_htu_pkg::htu_req_t req_i,
  // issue unit side
  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i,
  output bank_htu_pkg::htu_rsp_t rsp_o
);

  logic                      lookup_valid;
  bank_htu_pkg::htu_lookup_t lookup;
  logic [`BANK_HTU_SETS-1:0] set_sel;
  logic                      take;
  bank_htu_pkg::set_result_t set_results [`BANK_HTU_SETS];

  bank_htu_req_stage i_req_stage (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .req_i          (req_i),
    .take_i         (take),
    .lookup_valid_o (lookup_valid),
    .lookup_o       (lookup),
    .set_sel_o      (set_sel)
  );

  //----------------------------------------------------------------------
  // tag array, one entry per set
  //----------------------------------------------------------------------
  for (genvar s = 0; s < `BANK_HTU_SETS; s++) begin : g_set
    bank_htu_set_entry i_set_entry (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .sel_i    (set_sel[s]),
      .take_i   (take),
      .lookup_i (lookup),
      .result_o (set_results[s])
    );
  end

  bank_htu_resp_stage i_resp_stage (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .lookup_valid_i (lookup_valid),
    .lookup_i       (lookup),
    .set_results_i  (set_results),
    .take_o         (take),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_ready_i    (rsp_ready_i),
    .rsp_o          (rsp_o)
  );

endmodule

// ==== verilog/bank_htu_pkg.sv ====
`include "bank_htu_params.svh"

package bank_htu_pkg;

  typedef enum logic [1:0] {
    OP_READ  = 2'd0,
    OP_WRITE = 2'd1,
    OP_RSVD  = 2'd2,
    OP_INVAL = 2'd3
  } htu_opcode_e;

  // per half-line state, value 3 unused
  typedef enum logic [1:0] {
    ST_EMPTY = 2'd0,
    ST_CLEAN = 2'd1,
    ST_DIRTY = 2'd2
  } line_state_e;

  // crossbar request, addr[0] is address bit 4
  typedef struct packed {
    logic [`BANK_HTU_CH_ID_W-1:0]   ch_id;
    htu_opcode_e                    opcode;
    logic [`BANK_HTU_ADDR_W-1:0]    addr;
    logic [`BANK_HTU_WBUF_ID_W-1:0] wbuffer_id;
  } htu_req_t;

  typedef struct packed {
    logic [`BANK_HTU_CH_ID_W-1:0]   ch_id;
    htu_opcode_e                    opcode;
    logic [`BANK_HTU_SET_W-1:0]     set;
    logic [`BANK_HTU_TAG_W-1:0]     tag;
    logic                           offset;
    logic [`BANK_HTU_WBUF_ID_W-1:0] wbuffer_id;
  } htu_lookup_t;

  typedef struct packed {
    logic                       hit;
    logic [`BANK_HTU_WAY_W-1:0] way;
    logic                       evict;
    line_state_e                state0;
    line_state_e                state1;
  } set_result_t;

  typedef struct packed {
    logic [`BANK_HTU_CH_ID_W-1:0]   ch_id;
    logic                           write;
    logic                           evict;
    logic                           hit;
    logic                           linefill;
    logic [`BANK_HTU_SET_W-1:0]     set;
    logic [`BANK_HTU_WAY_W-1:0]     way;
    logic                           offset;
    logic [`BANK_HTU_WBUF_ID_W-1:0] wbuffer_id;
    line_state_e                    state0;
    line_state_e                    state1;
  } htu_rsp_t;

endpackage

// ==== verilog/bank_htu_req_stage.sv ====
`include "bank_htu_params.svh"

module bank_htu_req_stage (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  input  bank_htu_pkg::htu_req_t    req_i,
  input  logic                      take_i,
  output logic                      lookup_valid_o,
  output bank_htu_pkg::htu_lookup_t lookup_o,
  output logic [`BANK_HTU_SETS-1:0] set_sel_o
);

  logic                      valid_q;
  logic                      accept;
  bank_htu_pkg::htu_lookup_t lookup_d;
  bank_htu_pkg::htu_lookup_t lookup_q;

  // one slot, refilled in the same cycle it drains
  assign req_ready_o = ~valid_q | take_i;
  assign accept      = req_valid_i & req_ready_o;

  //----------------------------------------------------------------------
  // address split
  //----------------------------------------------------------------------
  always_comb begin
    lookup_d.ch_id      = req_i.ch_id;
    lookup_d.opcode     = req_i.opcode;
    lookup_d.offset     = req_i.addr[0];
    lookup_d.set        = req_i.addr[`BANK_HTU_SET_W:1];
    lookup_d.tag        = req_i.addr[`BANK_HTU_ADDR_W-1:`BANK_HTU_ADDR_W-`BANK_HTU_TAG_W];
    lookup_d.wbuffer_id = req_i.wbuffer_id;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (take_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      lookup_q <= lookup_d;
    end
  end

  assign lookup_valid_o = valid_q;
  assign lookup_o       = lookup_q;

  // set select is left unqualified, take gates every commit
  assign set_sel_o = `BANK_HTU_SETS'(1) << lookup_q.set;

endmodule

// ==== verilog/bank_htu_resp_stage.sv ====
`include "bank_htu_params.svh"

module bank_htu_resp_stage (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      lookup_valid_i,
  input  bank_htu_pkg::htu_lookup_t lookup_i,
  input  bank_htu_pkg::set_result_t set_results_i [`BANK_HTU_SETS],
  output logic                      take_o,
  output logic                      rsp_valid_o,
  input  logic                      rsp_ready_i,
  output bank_htu_pkg::htu_rsp_t    rsp_o
);

  bank_htu_pkg::set_result_t sel_res;
  bank_htu_pkg::line_state_e acc_state;
  bank_htu_pkg::htu_rsp_t    rsp_d;
  bank_htu_pkg::htu_rsp_t    rsp_q;
  logic                      rsp_valid_q;
  logic                      is_read;

  // output slot free or draining this cycle
  assign take_o = lookup_valid_i & (~rsp_valid_q | rsp_ready_i);

  assign sel_res   = set_results_i[lookup_i.set];
  assign acc_state = lookup_i.offset ? sel_res.state1 : sel_res.state0;
  assign is_read   = lookup_i.opcode == bank_htu_pkg::OP_READ;

  //----------------------------------------------------------------------
  // response build
  //----------------------------------------------------------------------
  always_comb begin
    rsp_d.ch_id      = lookup_i.ch_id;
    rsp_d.write      = lookup_i.opcode == bank_htu_pkg::OP_WRITE;
    rsp_d.evict      = sel_res.evict;
    rsp_d.hit        = sel_res.hit;
    // miss, or hit on a half never filled
    rsp_d.linefill   = is_read & (~sel_res.hit | (acc_state == bank_htu_pkg::ST_EMPTY));
    rsp_d.set        = lookup_i.set;
    rsp_d.way        = sel_res.way;
    rsp_d.offset     = lookup_i.offset;
    rsp_d.wbuffer_id = lookup_i.wbuffer_id;
    rsp_d.state0     = sel_res.state0;
    rsp_d.state1     = sel_res.state1;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (take_o) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_o) begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

// ==== verilog/bank_htu_set_entry.sv ====
`include "bank_htu_params.svh"

module bank_htu_set_entry (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      sel_i,
  input  logic                      take_i,
  input  bank_htu_pkg::htu_lookup_t lookup_i,
  output bank_htu_pkg::set_result_t result_o
);

  logic [`BANK_HTU_TAG_W-1:0] tag_q [`BANK_HTU_WAYS];
  logic [`BANK_HTU_WAYS-1:0]  valid_q;
  bank_htu_pkg::line_state_e  st0_q [`BANK_HTU_WAYS];
  bank_htu_pkg::line_state_e  st1_q [`BANK_HTU_WAYS];
  logic [`BANK_HTU_WAY_W-1:0] victim_q;

  logic [`BANK_HTU_WAYS-1:0]  hit_vec;
  logic                       hit;
  logic [`BANK_HTU_WAY_W-1:0] hit_way;
  logic [`BANK_HTU_WAY_W-1:0] way;
  logic                       is_read;
  logic                       is_write;
  logic                       is_inval;
  logic                       alloc;
  logic                       commit;
  bank_htu_pkg::line_state_e  cur0;
  bank_htu_pkg::line_state_e  cur1;
  bank_htu_pkg::line_state_e  nxt0;
  bank_htu_pkg::line_state_e  nxt1;
  logic                       nxt_valid;

  assign is_read  = lookup_i.opcode == bank_htu_pkg::OP_READ;
  assign is_write = lookup_i.opcode == bank_htu_pkg::OP_WRITE;
  assign is_inval = lookup_i.opcode == bank_htu_pkg::OP_INVAL;

  //----------------------------------------------------------------------
  // tag compare
  //----------------------------------------------------------------------
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < `BANK_HTU_WAYS; w++) begin
      hit_vec[w] = valid_q[w] && (tag_q[w] == lookup_i.tag);
      if (hit_vec[w]) begin
        hit_way = `BANK_HTU_WAY_W'(w);
      end
    end
  end

  assign hit   = |hit_vec;
  // miss takes the round-robin victim
  assign way   = hit ? hit_way : victim_q;
  assign cur0  = st0_q[way];
  assign cur1  = st1_q[way];
  assign alloc = (is_read | is_write) & ~hit;

  always_comb begin
    result_o.hit    = hit;
    result_o.way    = way;
    result_o.evict  = alloc & valid_q[way] &
                      ((cur0 == bank_htu_pkg::ST_DIRTY) | (cur1 == bank_htu_pkg::ST_DIRTY));
    result_o.state0 = cur0;
    result_o.state1 = cur1;
  end

  //----------------------------------------------------------------------
  // state update
  //----------------------------------------------------------------------
  // invalidate miss and reserved opcode leave the set alone
  assign commit = sel_i & take_i & (is_read | is_write | (is_inval & hit));

  always_comb begin
    nxt0      = alloc ? bank_htu_pkg::ST_EMPTY : cur0;
    nxt1      = alloc ? bank_htu_pkg::ST_EMPTY : cur1;
    nxt_valid = valid_q[way] | alloc;
    if (is_inval) begin
      nxt0      = bank_htu_pkg::ST_EMPTY;
      nxt1      = bank_htu_pkg::ST_EMPTY;
      nxt_valid = 1'b0;
    end else if (is_write) begin
      if (lookup_i.offset) begin
        nxt1 = bank_htu_pkg::ST_DIRTY;
      end else begin
        nxt0 = bank_htu_pkg::ST_DIRTY;
      end
    end else if (is_read) begin
      // fill marks an empty half clean, dirty data stays dirty
      if (lookup_i.offset && nxt1 == bank_htu_pkg::ST_EMPTY) begin
        nxt1 = bank_htu_pkg::ST_CLEAN;
      end else if (!lookup_i.offset && nxt0 == bank_htu_pkg::ST_EMPTY) begin
        nxt0 = bank_htu_pkg::ST_CLEAN;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q  <= '0;
      victim_q <= '0;
      for (int w = 0; w < `BANK_HTU_WAYS; w++) begin
        st0_q[w] <= bank_htu_pkg::ST_EMPTY;
        st1_q[w] <= bank_htu_pkg::ST_EMPTY;
      end
    end else if (commit) begin
      valid_q[way] <= nxt_valid;
      st0_q[way]   <= nxt0;
      st1_q[way]   <= nxt1;
      if (alloc) begin
        victim_q <= victim_q + `BANK_HTU_WAY_W'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (commit && alloc) begin
      tag_q[way] <= lookup_i.tag;
    end
  end

endmodule
